// ==== mpmem_bank_array.sv ====
// Four banks of 64 rows, each with two write ports and one read port.
// Drained entries are written at the edge where they leave the buffer.
// When both drained entries hit one address, the younger one wins.
// After reset a sweep zeroes one row of every bank per cycle, and ready
// rises with the last row. Reads take one cycle and do not see a write
// of the same edge.
`timescale 1ns/1ps
`include "mpmem_params.svh"

module mpmem_bank_array (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic [`MPMEM_NUMDRAIN-1:0]                       drain_vld,
  input  mpmem_pkg::mpmem_wr_entry_t [`MPMEM_NUMDRAIN-1:0]  drain_entries,
  input  logic [`MPMEM_NUMRDPT-1:0]                        rd_en,
  input  logic [`MPMEM_NUMRDPT*`MPMEM_BITVBNK-1:0]         rd_bank,
  input  logic [`MPMEM_NUMRDPT*`MPMEM_BITVROW-1:0]         rd_row,
  output logic [`MPMEM_NUMRDPT*`MPMEM_WIDTH-1:0]           rd_data,
  output logic                                             ready
);

  logic [`MPMEM_WIDTH-1:0] mem [`MPMEM_NUMVBNK][`MPMEM_NUMVROW];

  logic [`MPMEM_BITVROW-1:0] sweep_row;

  // clear sweep, one row of all banks per cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sweep_row <= '0;
      ready     <= 1'b0;
    end else if (!ready) begin
      sweep_row <= sweep_row + 1'b1;
      if (sweep_row == `MPMEM_BITVROW'(`MPMEM_NUMVROW - 1)) begin
        ready <= 1'b1;
      end
    end
  end

  // bank writes. later drain slot is younger, so it is written last.
  always_ff @(posedge clk) begin
    if (!ready) begin
      for (int b = 0; b < `MPMEM_NUMVBNK; b++) begin
        mem[b][sweep_row] <= '0;
      end
    end else begin
      for (int d = 0; d < `MPMEM_NUMDRAIN; d++) begin
        if (drain_vld[d]) begin
          mem[drain_entries[d].adr.br.bank][drain_entries[d].adr.br.row] <=
            drain_entries[d].data;
        end
      end
    end
  end

  // registered read, one per bank per cycle.
  always_ff @(posedge clk) begin
    for (int p = 0; p < `MPMEM_NUMRDPT; p++) begin
      if (rd_en[p]) begin
        rd_data[p*`MPMEM_WIDTH +: `MPMEM_WIDTH] <=
          mem[rd_bank[p*`MPMEM_BITVBNK +: `MPMEM_BITVBNK]]
             [rd_row[p*`MPMEM_BITVROW +: `MPMEM_BITVROW]];
      end
    end
  end

endmodule

// ==== mpmem_params.svh ====
// Sizing of the six-write, two-read memory.
// Bank and row bits must add up to the address bits, and the bank and
// row counts must match their index widths. The buffer holds
// 2**MPMEM_BITFIFO entries, so its count needs one extra bit.
`ifndef MPMEM_PARAMS_SVH
`define MPMEM_PARAMS_SVH

`define MPMEM_WIDTH     16
`define MPMEM_BITADDR   8

`define MPMEM_NUMVBNK   4
`define MPMEM_BITVBNK   2
`define MPMEM_BITVROW   6
`define MPMEM_NUMVROW   64

`define MPMEM_NUMWRPT   6
`define MPMEM_NUMRDPT   2
`define MPMEM_NUMDRAIN  2

// holds 0..MPMEM_NUMWRPT accepted writes in one cycle.
`define MPMEM_BITWRCNT  3

`define MPMEM_BITFIFO   5

`endif

// ==== mpmem_pkg.sv ====
// Types shared by the memory blocks.
// The address word is read either flat or as bank over row, and the
// bank sits in the upper bits.
`include "mpmem_params.svh"

package mpmem_pkg;

  typedef struct packed {
    logic [`MPMEM_BITVBNK-1:0] bank;  // upper address bits.
    logic [`MPMEM_BITVROW-1:0] row;
  } mpmem_bank_row_t;

  typedef union packed {
    logic [`MPMEM_BITADDR-1:0] flat;
    mpmem_bank_row_t           br;
  } mpmem_addr_u;

  // one buffered write, address over data.
  typedef struct packed {
    mpmem_addr_u              adr;
    logic [`MPMEM_WIDTH-1:0]  data;
  } mpmem_wr_entry_t;

endpackage

// ==== mpmem_port_decode.sv ====
// Front-end decode of the write and read ports. It is purely combinational.
// Active writes are packed into consecutive entries in rising port order,
// so a later port to the same address lands later in the buffer.
// All writes are dropped while ready is low.
// A read conflict is two active reads that hit the same bank.
`timescale 1ns/1ps
`include "mpmem_params.svh"

module mpmem_port_decode (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  logic [`MPMEM_NUMWRPT-1:0]                      write,
  input  logic [`MPMEM_NUMWRPT*`MPMEM_BITADDR-1:0]       wr_adr,
  input  logic [`MPMEM_NUMWRPT*`MPMEM_WIDTH-1:0]         din,
  input  logic [`MPMEM_NUMRDPT-1:0]                      read,
  input  logic [`MPMEM_NUMRDPT*`MPMEM_BITADDR-1:0]       rd_adr,
  input  logic                                           ready,
  output logic [`MPMEM_BITWRCNT-1:0]                     wr_cnt,
  output mpmem_pkg::mpmem_wr_entry_t [`MPMEM_NUMWRPT-1:0] wr_entries,
  output logic [`MPMEM_NUMRDPT*`MPMEM_BITVBNK-1:0]       rd_bank,
  output logic [`MPMEM_NUMRDPT*`MPMEM_BITVROW-1:0]       rd_row,
  output logic                                           rd_conflict_now
);

  mpmem_pkg::mpmem_addr_u rd_split [`MPMEM_NUMRDPT];

  // compaction of the active write ports.
  always_comb begin
    logic [`MPMEM_BITWRCNT-1:0] slot;
    mpmem_pkg::mpmem_wr_entry_t ent;
    slot       = '0;
    wr_entries = '0;
    for (int i = 0; i < `MPMEM_NUMWRPT; i++) begin
      ent.adr.flat = wr_adr[i*`MPMEM_BITADDR +: `MPMEM_BITADDR];
      ent.data     = din[i*`MPMEM_WIDTH +: `MPMEM_WIDTH];
      if (write[i] && ready) begin
        wr_entries[slot] = ent;
        slot             = slot + 1'b1;
      end
    end
    wr_cnt = slot;
  end

  // bank and row split of each read address.
  always_comb begin
    for (int p = 0; p < `MPMEM_NUMRDPT; p++) begin
      rd_split[p].flat = rd_adr[p*`MPMEM_BITADDR +: `MPMEM_BITADDR];
      rd_bank[p*`MPMEM_BITVBNK +: `MPMEM_BITVBNK] = rd_split[p].br.bank;
      rd_row[p*`MPMEM_BITVROW +: `MPMEM_BITVROW]  = rd_split[p].br.row;
    end
  end

  // only two read ports, so one pair to compare.
  assign rd_conflict_now = read[0] && read[1] &&
                           (rd_split[0].br.bank == rd_split[1].br.bank);

endmodule

// ==== mpmem_read_return.sv ====
// Read port control. Port 0 always wins a bank, and port 1 is refused when
// both ports hit the same bank. Valid, refusal and the physical address
// are registered to line up with the one-cycle bank read.
// rd_dout holds the last data read on a port and is only meaningful
// when rd_vld is high.
`timescale 1ns/1ps
`include "mpmem_params.svh"

module mpmem_read_return (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [`MPMEM_NUMRDPT-1:0]                 read,
  input  logic [`MPMEM_NUMRDPT*`MPMEM_BITVBNK-1:0]  rd_bank,
  input  logic [`MPMEM_NUMRDPT*`MPMEM_BITVROW-1:0]  rd_row,
  input  logic                                      rd_conflict_now,
  input  logic [`MPMEM_NUMRDPT*`MPMEM_WIDTH-1:0]    rd_data,
  output logic [`MPMEM_NUMRDPT-1:0]                 rd_en,
  output logic [`MPMEM_NUMRDPT-1:0]                 rd_vld,
  output logic [`MPMEM_NUMRDPT*`MPMEM_WIDTH-1:0]    rd_dout,
  output logic [`MPMEM_NUMRDPT*`MPMEM_BITADDR-1:0]  rd_padr,
  output logic                                      rd_conflict
);

  mpmem_pkg::mpmem_addr_u padr_nxt [`MPMEM_NUMRDPT];

  assign rd_en[0] = read[0];
  assign rd_en[1] = read[1] && !rd_conflict_now;  // port 1 loses the bank.

  always_comb begin
    for (int p = 0; p < `MPMEM_NUMRDPT; p++) begin
      padr_nxt[p].br.bank = rd_bank[p*`MPMEM_BITVBNK +: `MPMEM_BITVBNK];
      padr_nxt[p].br.row  = rd_row[p*`MPMEM_BITVROW +: `MPMEM_BITVROW];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld      <= '0;
      rd_conflict <= 1'b0;
    end else begin
      rd_vld      <= rd_en;
      rd_conflict <= rd_conflict_now;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MPMEM_NUMRDPT; p++) begin
      if (rd_en[p]) begin
        rd_padr[p*`MPMEM_BITADDR +: `MPMEM_BITADDR] <= padr_nxt[p].flat;
      end
    end
  end

  assign rd_dout = rd_data;  // bank output is already registered.

endmodule

// ==== mpmem_sva.sv ====
// Protocol checks bound into mpmem_top.
// fifo_cnt is the internal buffer count of the top level.
// Read checks hold for the cycle after each read, refused or not.
`timescale 1ns/1ps
`include "mpmem_params.svh"

module mpmem_sva (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [`MPMEM_NUMRDPT-1:0]                 read,
  input  logic [`MPMEM_NUMRDPT*`MPMEM_BITADDR-1:0]  rd_adr,
  input  logic [`MPMEM_NUMRDPT-1:0]                 rd_vld,
  input  logic                                      rd_conflict,
  input  logic [`MPMEM_BITFIFO:0]                   fifo_cnt
);

  logic same_bank;

  // bank bits sit at the top of each address.
  assign same_bank = read[0] && read[1] &&
                     (rd_adr[`MPMEM_BITADDR-1 -: `MPMEM_BITVBNK] ==
                      rd_adr[2*`MPMEM_BITADDR-1 -: `MPMEM_BITVBNK]);

  buffer_bound: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_cnt <= (`MPMEM_BITFIFO+1)'(2 ** `MPMEM_BITFIFO))
    else $error("write buffer holds more entries than its depth");

  port0_valid: assert property (@(posedge clk) disable iff (!rst_n)
    rd_vld[0] == $past(read[0]))
    else $error("port 0 valid does not follow its read by one cycle");

  port1_valid: assert property (@(posedge clk) disable iff (!rst_n)
    rd_vld[1] == $past(read[1] && !same_bank))
    else $error("port 1 valid does not follow its served read by one cycle");

  conflict_flag: assert property (@(posedge clk) disable iff (!rst_n)
    rd_conflict == $past(same_bank))
    else $error("conflict flag does not match a same-bank read pair");

endmodule

bind mpmem_top mpmem_sva sva_inst (
  .clk(clk),
  .rst_n(rst_n),
  .read(read),
  .rd_adr(rd_adr),
  .rd_vld(rd_vld),
  .rd_conflict(rd_conflict),
  .fifo_cnt(fifo_cnt)
);

// ==== mpmem_top.f ====
+incdir+.
mpmem_pkg.sv
mpmem_port_decode.sv
mpmem_write_buffer.sv
mpmem_bank_array.sv
mpmem_read_return.sv
mpmem_top.sv
mpmem_sva.sv
tb_mpmem_top.sv

// ==== mpmem_top.sv ====
// Six-write, two-read memory of 256 x 16 in four banks.
// Writes are strobes accepted only while ready is high, with no acknowledge.
// wr_bp is advisory, and writes that overrun the buffer are lost.
// A read returns bank contents one cycle later. A write still waiting in
// the buffer is not visible, so the read returns the older value.
`timescale 1ns/1ps
`include "mpmem_params.svh"

module mpmem_top (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic [`MPMEM_NUMWRPT-1:0]                 write,
  input  logic [`MPMEM_NUMWRPT*`MPMEM_BITADDR-1:0]  wr_adr,
  input  logic [`MPMEM_NUMWRPT*`MPMEM_WIDTH-1:0]    din,
  output logic                                      wr_bp,
  input  logic [`MPMEM_BITFIFO:0]                   bp_thr,
  input  logic [`MPMEM_NUMRDPT-1:0]                 read,
  input  logic [`MPMEM_NUMRDPT*`MPMEM_BITADDR-1:0]  rd_adr,
  output logic [`MPMEM_NUMRDPT-1:0]                 rd_vld,
  output logic [`MPMEM_NUMRDPT*`MPMEM_WIDTH-1:0]    rd_dout,
  output logic [`MPMEM_NUMRDPT*`MPMEM_BITADDR-1:0]  rd_padr,
  output logic                                      rd_conflict,
  output logic                                      ready
);

  logic [`MPMEM_BITWRCNT-1:0]                        wr_cnt;
  mpmem_pkg::mpmem_wr_entry_t [`MPMEM_NUMWRPT-1:0]   wr_entries;
  logic [`MPMEM_NUMRDPT*`MPMEM_BITVBNK-1:0]          rd_bank;
  logic [`MPMEM_NUMRDPT*`MPMEM_BITVROW-1:0]          rd_row;
  logic                                              rd_conflict_now;
  logic [`MPMEM_NUMDRAIN-1:0]                        drain_vld;
  mpmem_pkg::mpmem_wr_entry_t [`MPMEM_NUMDRAIN-1:0]  drain_entries;
  logic [`MPMEM_BITFIFO:0]                           fifo_cnt;
  logic [`MPMEM_NUMRDPT-1:0]                         rd_en;
  logic [`MPMEM_NUMRDPT*`MPMEM_WIDTH-1:0]            rd_data;

  mpmem_port_decode decode_inst (
    .clk, .rst_n, .write, .wr_adr, .din, .read, .rd_adr, .ready,
    .wr_cnt, .wr_entries, .rd_bank, .rd_row, .rd_conflict_now
  );

  mpmem_write_buffer buffer_inst (
    .clk, .rst_n, .wr_cnt, .wr_entries, .bp_thr, .ready,
    .drain_vld, .drain_entries, .wr_bp, .fifo_cnt
  );

  mpmem_bank_array bank_inst (
    .clk, .rst_n, .drain_vld, .drain_entries,
    .rd_en, .rd_bank, .rd_row, .rd_data, .ready
  );

  mpmem_read_return return_inst (
    .clk, .rst_n, .read, .rd_bank, .rd_row, .rd_conflict_now, .rd_data,
    .rd_en, .rd_vld, .rd_dout, .rd_padr, .rd_conflict
  );

endmodule

// ==== mpmem_write_buffer.sv ====
// Shared write buffer of 2**MPMEM_BITFIFO entries.
// Up to six entries are appended per cycle and up to two leave per cycle,
// oldest first. There is no overflow protection, so writers must obey
// wr_bp. wr_bp is the count of the previous cycle compared with bp_thr.
// The buffer is held empty while ready is low.
`timescale 1ns/1ps
`include "mpmem_params.svh"

module mpmem_write_buffer (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic [`MPMEM_BITWRCNT-1:0]                      wr_cnt,
  input  mpmem_pkg::mpmem_wr_entry_t [`MPMEM_NUMWRPT-1:0]  wr_entries,
  input  logic [`MPMEM_BITFIFO:0]                         bp_thr,
  input  logic                                            ready,
  output logic [`MPMEM_NUMDRAIN-1:0]                      drain_vld,
  output mpmem_pkg::mpmem_wr_entry_t [`MPMEM_NUMDRAIN-1:0] drain_entries,
  output logic                                            wr_bp,
  output logic [`MPMEM_BITFIFO:0]                         fifo_cnt
);

  localparam int DEPTH = 2 ** `MPMEM_BITFIFO;

  mpmem_pkg::mpmem_wr_entry_t mem [DEPTH];

  logic [`MPMEM_BITFIFO-1:0] head;
  logic [`MPMEM_BITFIFO-1:0] tail;
  logic [`MPMEM_BITFIFO:0]   drain_n;
  logic [`MPMEM_BITFIFO:0]   cnt_nxt;

  // drain is the smaller of the count and the drain width.
  always_comb begin
    if (fifo_cnt > `MPMEM_BITFIFO'(`MPMEM_NUMDRAIN)) begin
      drain_n = (`MPMEM_BITFIFO+1)'(`MPMEM_NUMDRAIN);
    end else begin
      drain_n = fifo_cnt;
    end
    cnt_nxt = fifo_cnt + (`MPMEM_BITFIFO+1)'(wr_cnt) - drain_n;
  end

  // the head entries leave at the next edge, where the banks take them.
  always_comb begin
    for (int d = 0; d < `MPMEM_NUMDRAIN; d++) begin
      drain_vld[d]     = (fifo_cnt > (`MPMEM_BITFIFO+1)'(d));
      drain_entries[d] = mem[head + `MPMEM_BITFIFO'(d)];
    end
  end

  // storage, appended at the tail in port order.
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MPMEM_NUMWRPT; i++) begin
      if (i < int'(wr_cnt)) begin
        mem[tail + `MPMEM_BITFIFO'(i)] <= wr_entries[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head     <= '0;
      tail     <= '0;
      fifo_cnt <= '0;
    end else if (!ready) begin
      head     <= '0;  // empty during the clear sweep.
      tail     <= '0;
      fifo_cnt <= '0;
    end else begin
      head     <= head + drain_n[`MPMEM_BITFIFO-1:0];
      tail     <= tail + `MPMEM_BITFIFO'(wr_cnt);
      fifo_cnt <= cnt_nxt;
    end
  end

  // one cycle behind the count.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bp <= 1'b0;
    end else begin
      wr_bp <= (fifo_cnt > bp_thr);
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# A simulation that stops with an error counts as a failure.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mpmem_top \
  -f mpmem_top.f -o sim_mpmem > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_mpmem > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } || {
  echo "simulation passed"; exit 0; }

// ==== tb_mpmem_top.sv ====
// Testbench for the six-write, two-read memory.
// Inputs change on the rising edge and outputs are checked at the falling edge.
// Reads are only checked once the write buffer has drained, since a read
// does not see writes that still wait in the buffer.
`timescale 1ns/1ps
`include "mpmem_params.svh"

module tb_mpmem_top;

  logic                                      clk;
  logic                                      rst_n;
  logic [`MPMEM_NUMWRPT-1:0]                 write;
  logic [`MPMEM_NUMWRPT*`MPMEM_BITADDR-1:0]  wr_adr;
  logic [`MPMEM_NUMWRPT*`MPMEM_WIDTH-1:0]    din;
  logic                                      wr_bp;
  logic [`MPMEM_BITFIFO:0]                   bp_thr;
  logic [`MPMEM_NUMRDPT-1:0]                 read;
  logic [`MPMEM_NUMRDPT*`MPMEM_BITADDR-1:0]  rd_adr;
  logic [`MPMEM_NUMRDPT-1:0]                 rd_vld;
  logic [`MPMEM_NUMRDPT*`MPMEM_WIDTH-1:0]    rd_dout;
  logic [`MPMEM_NUMRDPT*`MPMEM_BITADDR-1:0]  rd_padr;
  logic                                      rd_conflict;
  logic                                      ready;

  logic [`MPMEM_WIDTH-1:0] shadow [2 ** `MPMEM_BITADDR];  // expected bank contents.

  logic [`MPMEM_NUMWRPT-1:0]                 nx_write;
  logic [`MPMEM_NUMWRPT*`MPMEM_BITADDR-1:0]  nx_wr_adr;
  logic [`MPMEM_NUMWRPT*`MPMEM_WIDTH-1:0]    nx_din;
  logic [`MPMEM_NUMRDPT-1:0]                 nx_read;
  logic [`MPMEM_NUMRDPT*`MPMEM_BITADDR-1:0]  nx_rd_adr;
  logic [`MPMEM_BITFIFO:0]                   nx_thr;

  int cnt_model;  // buffer count after the latest edge.
  int cnt_prev;
  int pend_cnt;   // writes driven, not yet sampled.
  int thr_seen;

  mpmem_top mpmem_top_inst (
    .clk, .rst_n, .write, .wr_adr, .din, .wr_bp, .bp_thr, .read, .rd_adr,
    .rd_vld, .rd_dout, .rd_padr, .rd_conflict, .ready
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (exp_v === act_v) else
      stop_with_failure($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h",
                                  name, exp_v, act_v));
  endtask

  // one clock: update the count model, drive the staged inputs, check wr_bp.
  task automatic tick();
    int drain;
    @(posedge clk);
    cnt_prev  = cnt_model;
    thr_seen  = int'(bp_thr);
    drain     = (cnt_model > `MPMEM_NUMDRAIN) ? `MPMEM_NUMDRAIN : cnt_model;
    cnt_model = cnt_model + pend_cnt - drain;
    pend_cnt  = $countones(nx_write);
    write  <= nx_write;
    wr_adr <= nx_wr_adr;
    din    <= nx_din;
    read   <= nx_read;
    rd_adr <= nx_rd_adr;
    bp_thr <= nx_thr;
    nx_write = '0;
    nx_read  = '0;
    @(negedge clk);
    check_value("wr_bp", 32'(cnt_prev > thr_seen), 32'(wr_bp));
  endtask

  task automatic wait_ready();
    int guard;
    guard = 0;
    while (ready !== 1'b1) begin
      tick();
      guard++;
      if (guard > 200) stop_with_failure("ready did not rise after reset");
    end
  endtask

  // bp_thr at zero makes wr_bp a buffer-not-empty flag.
  task automatic drain_buffer();
    int guard;
    nx_thr = '0;
    tick();
    tick();
    guard = 0;
    while (wr_bp !== 1'b0) begin
      tick();
      guard++;
      if (guard > 100) stop_with_failure("write buffer did not drain");
    end
  endtask

  task automatic post_writes(input logic [5:0] mask, input logic [47:0] adrs,
                             input logic [95:0] data);
    for (int i = 0; i < `MPMEM_NUMWRPT; i++) begin
      if (mask[i]) shadow[adrs[i*8 +: 8]] = data[i*16 +: 16];  // higher port lands last.
    end
    nx_write  = mask;
    nx_wr_adr = adrs;
    nx_din    = data;
    tick();
  endtask

  task automatic read_check(input string name, input logic [1:0] rmask,
                            input logic [7:0] a0, input logic [7:0] a1);
    logic       conflict;
    logic [1:0] exp_vld;
    conflict = rmask[0] && rmask[1] && (a0[7:6] == a1[7:6]);
    exp_vld  = {rmask[1] && !conflict, rmask[0]};
    nx_read   = rmask;
    nx_rd_adr = {a1, a0};
    tick();
    tick();
    check_value({name, " rd_vld"}, 32'(exp_vld), 32'(rd_vld));
    check_value({name, " rd_conflict"}, 32'(conflict), 32'(rd_conflict));
    if (exp_vld[0]) begin
      check_value({name, " rd_dout0"}, 32'(shadow[a0]), 32'(rd_dout[15:0]));
      check_value({name, " rd_padr0"}, 32'({a0[7:6], a0[5:0]}), 32'(rd_padr[7:0]));
    end
    if (exp_vld[1]) begin
      check_value({name, " rd_dout1"}, 32'(shadow[a1]), 32'(rd_dout[31:16]));
      check_value({name, " rd_padr1"}, 32'({a1[7:6], a1[5:0]}), 32'(rd_padr[15:8]));
    end
  endtask

  // addresses i and i+128 always sit in different banks.
  task automatic read_all(input string name);
    for (int a = 0; a < 128; a++) begin
      read_check(name, 2'b11, 8'(a), 8'(a + 128));
    end
  endtask

  task automatic random_bursts(input int cycles);
    logic [5:0]  mask;
    logic [47:0] adrs;
    logic [95:0] data;
    int          src;
    int          dst;
    for (int c = 0; c < cycles; c++) begin
      mask = 6'($urandom);
      for (int i = 0; i < `MPMEM_NUMWRPT; i++) begin
        adrs[i*8 +: 8]   = 8'($urandom);
        data[i*16 +: 16] = 16'($urandom);
      end
      if ($urandom_range(2) == 0) begin  // two ports on one address.
        src = int'($urandom_range(4));
        dst = src + 1 + int'($urandom_range(4 - src));
        adrs[dst*8 +: 8] = adrs[src*8 +: 8];
        mask[src] = 1'b1;
        mask[dst] = 1'b1;
      end
      if (wr_bp) mask = '0;
      post_writes(mask, adrs, data);
    end
  endtask

  task automatic backpressure_burst(input int cycles);
    logic [47:0] adrs;
    logic [95:0] data;
    logic        seen_bp;
    seen_bp = 1'b0;
    nx_thr  = 6'd4;
    for (int c = 0; c < cycles; c++) begin
      for (int i = 0; i < `MPMEM_NUMWRPT; i++) begin
        adrs[i*8 +: 8]   = 8'($urandom);
        data[i*16 +: 16] = 16'($urandom);
      end
      if (wr_bp) begin
        seen_bp = 1'b1;
        post_writes('0, adrs, data);
      end else begin
        post_writes('1, adrs, data);
      end
    end
    check_value("bp_rise", 32'd1, 32'(seen_bp));
  endtask

  task automatic conflict_reads(input int count);
    logic [7:0] a0;
    logic [7:0] a1;
    for (int n = 0; n < count; n++) begin
      a0 = 8'($urandom);
      a1 = {a0[7:6], 6'($urandom)};
      read_check("same_bank", 2'b11, a0, a1);
      a1 = {a0[7:6] + 2'd1 + 2'($urandom_range(2)), 6'($urandom)};
      read_check("other_bank", 2'b11, a0, a1);
      read_check("port1_only", 2'b10, a0, a1);
    end
  endtask

  initial begin
    #100000;
    stop_with_failure("simulation ran past its time limit");
  end

  initial begin
    void'($urandom(32'ha8fe));
    rst_n     = 1'b0;
    write     = '0;
    wr_adr    = '0;
    din       = '0;
    bp_thr    = '0;
    read      = '0;
    rd_adr    = '0;
    nx_write  = '0;
    nx_wr_adr = '0;
    nx_din    = '0;
    nx_read   = '0;
    nx_rd_adr = '0;
    nx_thr    = '0;
    cnt_model = 0;
    cnt_prev  = 0;
    pend_cnt  = 0;
    thr_seen  = 0;
    for (int a = 0; a < 2 ** `MPMEM_BITADDR; a++) shadow[a] = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    wait_ready();
    read_all("reset_clear");
    nx_thr = 6'd12;
    random_bursts(80);
    drain_buffer();
    read_all("burst_readback");
    backpressure_burst(40);
    drain_buffer();
    read_all("bp_readback");
    conflict_reads(20);
    $display("Result: PASSED");
    $finish;
  end

endmodule
